/* flist.f */
+incdir+include
hdl/sys_pkg.sv
hdl/mem_dp.sv
hdl/regfile.sv
hdl/fu_alu.sv
hdl/fu_mult.sv
hdl/prf_exec_top.sv
tb/prf_wb_checker.sv
tb/tb_prf_exec.sv

/* hdl/fu_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module fu_alu import sys_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  exec_packet_t exec,
    output wb_packet_t   wb
);

    // Combinational result of the current operation
    data alu_result;

    // Opcode decode
    always_comb begin
        case (exec.op)
            op_add:  alu_result = exec.rs1_value + exec.rs2_value;
            op_sub:  alu_result = exec.rs1_value - exec.rs2_value;
            op_and:  alu_result = exec.rs1_value & exec.rs2_value;
            op_or:   alu_result = exec.rs1_value | exec.rs2_value;
            op_xor:  alu_result = exec.rs1_value ^ exec.rs2_value;
            // Shift amount from low 5 bits only
            op_sll:  alu_result = exec.rs1_value << exec.rs2_value[4:0];
            op_li:   alu_result = exec.imm;
            // Multiply belongs to the other lane
            default: alu_result = '0;
        endcase
    end

    // Writeback register, one cycle after exec
    always_ff @(posedge clock) begin
        if (exec.valid) begin
            wb.dest   <= exec.dest;
            wb.result <= alu_result;
        end
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= exec.valid;
        end
    end

    // Issue must steer multiplies to the multiplier lane
    a_no_mult_on_alu: assert property (
        @(posedge clock) disable iff (reset)
        exec.valid |-> (exec.op != op_mul)
    ) else $error("fu_alu: multiply issued to an ALU lane");

endmodule

`default_nettype wire

/* hdl/fu_mult.sv */
`timescale 1ns/100ps
`default_nettype none

module fu_mult import sys_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  exec_packet_t exec,
    output wb_packet_t   wb
);

    localparam int half_w = $bits(data) / 2;

    // Stage 1 contents, cross terms only need their low half
    typedef struct packed {
        logic              valid;
        phys_reg_idx       dest;
        data               pp_ll;
        logic [half_w-1:0] pp_lh;
        logic [half_w-1:0] pp_hl;
    } mult_stage_t;

    mult_stage_t s1;
    // Full-width partial products
    data pp_ll;
    data pp_lh;
    data pp_hl;

    // Half by half products, high by high drops out of the low word
    always_comb begin
        pp_ll = data'(exec.rs1_value[half_w-1:0]) * data'(exec.rs2_value[half_w-1:0]);
        pp_lh = data'(exec.rs1_value[half_w-1:0]) * data'(exec.rs2_value[2*half_w-1:half_w]);
        pp_hl = data'(exec.rs1_value[2*half_w-1:half_w]) * data'(exec.rs2_value[half_w-1:0]);
    end

    ////////////////////////////////////////////////////////////
    // Stage 1, partial products
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (exec.valid) begin
            s1.dest  <= exec.dest;
            s1.pp_ll <= pp_ll;
            s1.pp_lh <= pp_lh[half_w-1:0];
            s1.pp_hl <= pp_hl[half_w-1:0];
        end
        if (reset) begin
            s1.valid <= 1'b0;
        end else begin
            s1.valid <= exec.valid;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2, final sum into the writeback packet
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (s1.valid) begin
            wb.dest   <= s1.dest;
            // Cross terms wrap within the upper half
            wb.result <= s1.pp_ll + {s1.pp_lh + s1.pp_hl, {half_w{1'b0}}};
        end
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= s1.valid;
        end
    end

    a_mult_only: assert property (
        @(posedge clock) disable iff (reset)
        exec.valid |-> (exec.op == op_mul)
    ) else $error("fu_mult: non-multiply issued to the multiplier lane");

endmodule

`default_nettype wire

/* hdl/mem_dp.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_dp #(
    parameter int width       = 32,
    parameter int depth       = 64,
    parameter int read_ports  = 2,
    parameter int write_ports = 1,
    parameter bit bypass_en   = 1'b0
)(
    input  logic                                   clock,
    input  logic                                   reset,
    // Read side
    input  logic [read_ports-1:0]                  re,
    input  logic [read_ports-1:0][$clog2(depth)-1:0]  raddr,
    output logic [read_ports-1:0][width-1:0]       rdata,
    // Write side
    input  logic [write_ports-1:0]                 we,
    input  logic [write_ports-1:0][$clog2(depth)-1:0] waddr,
    input  logic [write_ports-1:0][width-1:0]      wdata
);

    // Storage array
    logic [width-1:0] mem [depth];

    ////////////////////////////////////////////////////////////
    // Write ports
    ////////////////////////////////////////////////////////////

    // Every enabled port writes on the edge
    // Later ports override earlier ones on a shared address
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int d = 0; d < depth; d++) begin
                mem[d] <= '0;
            end
        end else begin
            for (int w = 0; w < write_ports; w++) begin
                if (we[w]) begin
                    mem[waddr[w]] <= wdata[w];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Combinational read, disabled port returns zero
    always_comb begin
        for (int r = 0; r < read_ports; r++) begin
            if (re[r]) begin
                rdata[r] = mem[raddr[r]];
                // Forward same-cycle writes
                // Loop order lets the highest port win
                if (bypass_en) begin
                    for (int w = 0; w < write_ports; w++) begin
                        if (we[w] && (waddr[w] == raddr[r])) begin
                            rdata[r] = wdata[w];
                        end
                    end
                end
            end else begin
                rdata[r] = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/prf_exec_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sys_defs.svh"

module prf_exec_top import sys_pkg::*; (
    input  logic                         clock,
    input  logic                         reset,
    // Lanes 0 and 1 are ALU, the last lane is the multiplier
    input  issue_packet_t [`NUM_FU-1:0]  issue,
    output wb_packet_t    [`NUM_FU-1:0]  wb
);

    // Register file read and write buses
    phys_reg_idx  [`NUM_FU-1:0] read_idx_1;
    phys_reg_idx  [`NUM_FU-1:0] read_idx_2;
    data          [`NUM_FU-1:0] read_out_1;
    data          [`NUM_FU-1:0] read_out_2;
    phys_reg_idx  [`NUM_FU-1:0] write_idx;
    logic         [`NUM_FU-1:0] write_en;
    data          [`NUM_FU-1:0] write_data;
    // Per-lane issue registers
    exec_packet_t [`NUM_FU-1:0] exec;

    ////////////////////////////////////////////////////////////
    // Operand read and issue registers
    ////////////////////////////////////////////////////////////

    // Sources address the file straight from the issue port
    // Writeback drives the write ports in the same cycle
    always_comb begin
        for (int i = 0; i < `NUM_FU; i++) begin
            read_idx_1[i] = issue[i].src1;
            read_idx_2[i] = issue[i].src2;
            write_en[i]   = wb[i].valid;
            write_idx[i]  = wb[i].dest;
            write_data[i] = wb[i].result;
        end
    end

    // Packet and operands captured together
    always_ff @(posedge clock) begin
        for (int i = 0; i < `NUM_FU; i++) begin
            if (issue[i].valid) begin
                exec[i].op        <= issue[i].op;
                exec[i].src1      <= issue[i].src1;
                exec[i].src2      <= issue[i].src2;
                exec[i].dest      <= issue[i].dest;
                exec[i].imm       <= issue[i].imm;
                exec[i].rs1_value <= read_out_1[i];
                exec[i].rs2_value <= read_out_2[i];
            end
            if (reset) begin
                exec[i].valid <= 1'b0;
            end else begin
                exec[i].valid <= issue[i].valid;
            end
        end
    end

    regfile #(
        .depth (`PHYS_REG_SZ_R10K),
        .num_fu(`NUM_FU)
    ) i_regfile (
        .clock     (clock),
        .read_idx_1(read_idx_1),
        .read_idx_2(read_idx_2),
        .write_idx (write_idx),
        .write_en  (write_en),
        .write_data(write_data),
        .read_out_1(read_out_1),
        .read_out_2(read_out_2)
    );

    ////////////////////////////////////////////////////////////
    // Functional unit lanes
    ////////////////////////////////////////////////////////////

    // ALU lanes first
    for (genvar g = 0; g < `NUM_FU_ALU; g++) begin : g_alu
        fu_alu i_fu_alu (
            .clock(clock),
            .reset(reset),
            .exec (exec[g]),
            .wb   (wb[g])
        );
    end

    // multiplier sits right after the ALUs
    fu_mult i_fu_mult (
        .clock(clock),
        .reset(reset),
        .exec (exec[`NUM_FU_ALU]),
        .wb   (wb[`NUM_FU_ALU])
    );

endmodule

`default_nettype wire

/* hdl/regfile.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sys_defs.svh"

module regfile import sys_pkg::*; #(
    parameter int depth  = `PHYS_REG_SZ_R10K,
    parameter int num_fu = `NUM_FU
)(
    input  logic                     clock,
    // One read pair and one write port per lane
    input  phys_reg_idx [num_fu-1:0] read_idx_1,
    input  phys_reg_idx [num_fu-1:0] read_idx_2,
    input  phys_reg_idx [num_fu-1:0] write_idx,
    input  logic        [num_fu-1:0] write_en,
    input  data         [num_fu-1:0] write_data,
    output data         [num_fu-1:0] read_out_1,
    output data         [num_fu-1:0] read_out_2
);

    // Raw array read data
    data [num_fu-1:0] rdata_1;
    data [num_fu-1:0] rdata_2;
    // Port enables with the zero register masked off
    logic [num_fu-1:0] re_1;
    logic [num_fu-1:0] re_2;
    logic [num_fu-1:0] we;
    // Two lanes hitting one register
    logic write_conflict;

    // Full depth kept so indices need no offset
    mem_dp #(
        .width      ($bits(data)),
        .depth      (depth),
        .read_ports (2 * num_fu),
        .write_ports(num_fu),
        .bypass_en  (1'b1)
    ) i_regfile_mem (
        .clock(clock),
        .reset(1'b0),
        .re   ({re_2, re_1}),
        .raddr({read_idx_2, read_idx_1}),
        .rdata({rdata_2, rdata_1}),
        .we   (we),
        .waddr(write_idx),
        .wdata(write_data)
    );

    // Zero register reads as zero, never written
    // A disabled array read already returns zero
    always_comb begin
        for (int i = 0; i < num_fu; i++) begin
            re_1[i]       = (read_idx_1[i] != phys_reg_idx'(`ZERO_REG));
            re_2[i]       = (read_idx_2[i] != phys_reg_idx'(`ZERO_REG));
            read_out_1[i] = rdata_1[i];
            read_out_2[i] = rdata_2[i];
            we[i]         = write_en[i] && (write_idx[i] != phys_reg_idx'(`ZERO_REG));
        end
    end

    // Pairwise compare of enabled writes across lanes
    always_comb begin
        write_conflict = 1'b0;
        for (int i = 0; i < num_fu; i++) begin
            for (int j = i + 1; j < num_fu; j++) begin
                if (we[i] && we[j] && (write_idx[i] == write_idx[j])) begin
                    write_conflict = 1'b1;
                end
            end
        end
    end

    a_no_write_conflict: assert property (@(posedge clock) !write_conflict)
        else $error("regfile: two lanes write the same physical register");

endmodule

`default_nettype wire

/* hdl/sys_pkg.sv */
`default_nettype none

`include "sys_defs.svh"

package sys_pkg;

    ////////////////////////////////////////////////////////////
    // Basic index and data types
    ////////////////////////////////////////////////////////////

    // Physical register index, log2 of the file depth
    typedef logic [$clog2(`PHYS_REG_SZ_R10K)-1:0] phys_reg_idx;

    // One machine word
    typedef logic [`XLEN-1:0] data;

    // Lane operations
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,  // shift by low 5 bits of source 2
        op_li  = 3'd6,  // write the immediate
        op_mul = 3'd7   // low word of the product
    } fu_op_e;

    ////////////////////////////////////////////////////////////
    // Pipeline packets
    ////////////////////////////////////////////////////////////

    // Issued operation, valid is a one-cycle strobe
    typedef struct packed {
        logic        valid;
        fu_op_e      op;
        phys_reg_idx src1;
        phys_reg_idx src2;
        phys_reg_idx dest;
        data         imm;
    } issue_packet_t;

    // Issued operation plus its read operands
    typedef struct packed {
        logic        valid;
        fu_op_e      op;
        phys_reg_idx src1;
        phys_reg_idx src2;
        phys_reg_idx dest;
        data         imm;
        data         rs1_value;
        data         rs2_value;
    } exec_packet_t;

    // Result headed for the register file
    typedef struct packed {
        logic        valid;
        phys_reg_idx dest;
        data         result;
    } wb_packet_t;

endpackage

`default_nettype wire

/* include/sys_defs.svh */
`ifndef SYS_DEFS_SVH
`define SYS_DEFS_SVH

// Physical register file depth
`define PHYS_REG_SZ_R10K 64

// Functional unit lane counts
`define NUM_FU_ALU   2
`define NUM_FU_MULT  1
// Memory and branch units live outside this slice
`define NUM_FU_STORE 0
`define NUM_FU_LD    0
`define NUM_FU_BR    0

// Total lanes, one register file port group per lane
`define NUM_FU (`NUM_FU_ALU + `NUM_FU_MULT + `NUM_FU_STORE + `NUM_FU_LD + `NUM_FU_BR)

// Hardwired zero register
`define ZERO_REG 0

// Datapath width
`define XLEN 32

`endif

/* tb/prf_wb_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sys_defs.svh"

module prf_wb_checker import sys_pkg::*; (
    input logic                      clock,
    input logic                      reset,
    input wb_packet_t [`NUM_FU-1:0]  wb
);

    // One expected writeback, with the cycle it must show up in
    typedef struct packed {
        logic [31:0] cycle;
        phys_reg_idx dest;
        data         result;
    } wb_expect_t;

    // Per-lane expected writebacks, oldest first
    wb_expect_t exp_q [`NUM_FU][$];
    wb_expect_t popped;

    // Rising edges seen since time zero
    int unsigned cycle = 0;
    int unsigned checks = 0;
    int unsigned errors = 0;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // Single compare point for every check in the run
    task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // Queue a writeback for a lane
    task automatic expect_wb(input int lane, input int unsigned at_cycle,
                             input phys_reg_idx dest, input data result);
        exp_q[lane].push_back({at_cycle, dest, result});
    endtask

    // Writebacks still outstanding over all lanes
    function automatic int pending();
        int total;
        total = 0;
        for (int l = 0; l < `NUM_FU; l++) begin
            total += exp_q[l].size();
        end
        return total;
    endfunction

    // Sampled mid-cycle, away from the active edge
    always @(negedge clock) begin
        if (!reset) begin
            for (int l = 0; l < `NUM_FU; l++) begin
                if (wb[l].valid && exp_q[l].size() == 0) begin
                    errors++;
                    $display("lane %0d wrote back register %0d at %0t ns with no operation in flight",
                             l, wb[l].dest, $time);
                end else if (wb[l].valid) begin
                    popped = exp_q[l].pop_front();
                    compare(cycle, popped.cycle, $sformatf("lane %0d writeback cycle", l));
                    compare(wb[l].dest, popped.dest, $sformatf("lane %0d writeback dest", l));
                    compare(wb[l].result, popped.result, $sformatf("lane %0d result", l));
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_prf_exec.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sys_defs.svh"

module tb_prf_exec import sys_pkg::*; ();

    localparam int alu_latency  = 2;
    localparam int mult_latency = 3;
    localparam int mult_lane    = `NUM_FU_ALU;

    // Cycle budget of the whole run, drain slack included
    localparam int reset_cycles      = 5;
    localparam int fill_cycles       = 32;
    localparam int random_alu_cycles = 40;
    localparam int mult_ops          = 10;
    localparam int mixed_cycles      = 60;
    localparam int readback_cycles   = 32;
    localparam int fixed_cycles      = 16;
    localparam int drain_slack       = 8 * 8;
    localparam int total_cycles      = reset_cycles + fill_cycles + random_alu_cycles + mult_ops
                                     + mixed_cycles + readback_cycles + fixed_cycles + drain_slack;
    localparam int watchdog_ns       = 4 * total_cycles + 200;

    logic                         clock;
    logic                         reset;
    issue_packet_t [`NUM_FU-1:0]  issue;
    wb_packet_t    [`NUM_FU-1:0]  wb;

    // Model register file, entry 0 never written
    data         model_rf [`PHYS_REG_SZ_R10K];
    // First cycle a register may be read as a source
    int unsigned ready_at [`PHYS_REG_SZ_R10K];
    int unsigned tests_run;
    int unsigned errors_before;

    prf_exec_top i_prf_exec_top (
        .clock(clock),
        .reset(reset),
        .issue(issue),
        .wb   (wb)
    );

    prf_wb_checker i_wb_checker (
        .clock(clock),
        .reset(reset),
        .wb   (wb)
    );

    always #2 clock = ~clock;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic data ref_result(input fu_op_e op, input phys_reg_idx src1,
                                       input phys_reg_idx src2, input data imm);
        data a;
        data b;
        a = model_rf[src1];
        b = model_rf[src2];
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_li:   return imm;
            // Context width keeps the low word
            op_mul:  return a * b;
            default: return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    // Next edge, then drop every strobe
    task automatic step_cycle();
        @(posedge clock);
        #1;
        for (int l = 0; l < `NUM_FU; l++) begin
            issue[l].valid = 1'b0;
        end
    endtask

    task automatic issue_op(input int lane, input fu_op_e op, input phys_reg_idx src1,
                            input phys_reg_idx src2, input phys_reg_idx dest, input data imm);
        data         expected;
        int unsigned done_cycle;
        expected   = ref_result(op, src1, src2, imm);
        done_cycle = i_wb_checker.cycle + ((op == op_mul) ? mult_latency : alu_latency);
        issue[lane] = '{valid: 1'b1, op: op, src1: src1, src2: src2, dest: dest, imm: imm};
        i_wb_checker.expect_wb(lane, done_cycle, dest, expected);
        // Register 0 keeps its zero
        if (dest != phys_reg_idx'(`ZERO_REG)) begin
            model_rf[dest] = expected;
            ready_at[dest] = done_cycle;
        end
    endtask

    // Random register whose value is already visible, else register 0
    function automatic phys_reg_idx pick_source();
        phys_reg_idx r;
        for (int t = 0; t < 16; t++) begin
            r = phys_reg_idx'($urandom_range(`PHYS_REG_SZ_R10K - 1, 1));
            if (ready_at[r] <= i_wb_checker.cycle) begin
                return r;
            end
        end
        return phys_reg_idx'(`ZERO_REG);
    endfunction

    // Disjoint dest ranges per lane, so lanes never collide
    function automatic phys_reg_idx pick_dest(input int lane);
        return phys_reg_idx'(lane * 21 + $urandom_range(21, 1));
    endfunction

    task automatic wait_for_drain();
        while (i_wb_checker.pending() != 0) begin
            step_cycle();
        end
    endtask

    task automatic report_test(input string name);
        wait_for_drain();
        tests_run++;
        $display("test %0d %s: %s", tests_run, name,
                 (i_wb_checker.errors == errors_before) ? "passed" : "failed");
        errors_before = i_wb_checker.errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        issue         = '0;
        tests_run     = 0;
        errors_before = 0;
        void'($urandom(32'ha9bd));
        for (int r = 0; r < `PHYS_REG_SZ_R10K; r++) begin
            model_rf[r] = '0;
            ready_at[r] = (r == `ZERO_REG) ? 0 : 32'hffff_ffff;
        end
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;

        // Quiet lanes after reset, then load every register
        for (int l = 0; l < `NUM_FU; l++) begin
            i_wb_checker.compare(wb[l].valid, 1'b0, $sformatf("lane %0d wb valid after reset", l));
        end
        for (int r = 1; r < `PHYS_REG_SZ_R10K; r += 2) begin
            step_cycle();
            issue_op(0, op_li, 0, 0, phys_reg_idx'(r), $urandom());
            if (r + 1 < `PHYS_REG_SZ_R10K) begin
                issue_op(1, op_li, 0, 0, phys_reg_idx'(r + 1), $urandom());
            end
        end
        report_test("reset and load-immediate");

        // Write to register 0 is seen on wb only
        step_cycle();
        issue_op(0, op_li, 0, 0, 0, 32'h1234_5678);
        wait_for_drain();
        step_cycle();
        issue_op(0, op_add, 0, 5, 20, 0);
        issue_op(1, op_or, 0, 0, 21, 0);
        report_test("zero register");

        for (int n = 0; n < random_alu_cycles; n++) begin
            step_cycle();
            for (int l = 0; l < `NUM_FU_ALU; l++) begin
                issue_op(l, fu_op_e'($urandom_range(6, 0)), pick_source(), pick_source(),
                         pick_dest(l), $urandom());
            end
        end
        report_test("random ALU operations");

        // Consumers issued in the producer's wb cycle
        step_cycle();
        issue_op(0, op_li, 0, 0, 10, $urandom());
        repeat (alu_latency) step_cycle();
        issue_op(1, op_add, 10, 0, 30, 0);
        issue_op(mult_lane, op_mul, 10, 11, 50, 0);
        repeat (mult_latency) step_cycle();
        issue_op(0, op_xor, 50, 30, 12, 0);
        report_test("write-to-read bypass");

        for (int n = 0; n < mult_ops; n++) begin
            step_cycle();
            issue_op(mult_lane, op_mul, pick_source(), pick_source(), pick_dest(mult_lane), 0);
        end
        report_test("multiplier pipeline");

        for (int n = 0; n < mixed_cycles; n++) begin
            step_cycle();
            for (int l = 0; l < `NUM_FU_ALU; l++) begin
                if ($urandom_range(3, 0) != 0) begin
                    issue_op(l, fu_op_e'($urandom_range(6, 0)), pick_source(), pick_source(),
                             pick_dest(l), $urandom());
                end
            end
            if ($urandom_range(3, 0) != 0) begin
                issue_op(mult_lane, op_mul, pick_source(), pick_source(), pick_dest(mult_lane), 0);
            end
        end
        wait_for_drain();
        // Every register read back through an add with register 0
        for (int r = 1; r < `PHYS_REG_SZ_R10K; r += 2) begin
            step_cycle();
            issue_op(0, op_add, phys_reg_idx'(r), 0, phys_reg_idx'(r), 0);
            if (r + 1 < `PHYS_REG_SZ_R10K) begin
                issue_op(1, op_add, phys_reg_idx'(r + 1), 0, phys_reg_idx'(r + 1), 0);
            end
        end
        report_test("mixed stream and readback");

        $display("tests %0d, checks %0d, errors %0d",
                 tests_run, i_wb_checker.checks, i_wb_checker.errors);
        if (i_wb_checker.errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Run length bound
    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
